// ==== flist.f ====
+incdir+include
hdl/dhcp_rx_pkg.sv
hdl/dhcp_hdr_capture.sv
hdl/dhcp_opt_parser.sv
hdl/dhcp_rsp_queue.sv
hdl/dhcp_rx_top.sv
testbench/dhcp_rx_tb.sv

// ==== hdl/dhcp_hdr_capture.sv ====
`timescale 1ns/10ps
`include "dhcp_rx_consts.svh"

module dhcp_hdr_capture (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  dhcp_rx_pkg::udp_strm_t strm,
  input  dhcp_rx_pkg::udp_meta_t meta,
  input  logic [31:0]            cli_xid,
  output dhcp_rx_pkg::udp_strm_t opt_strm,
  output logic                   opt_en,
  output dhcp_rx_pkg::dhcp_hdr_t hdr,
  output logic                   hdr_err,
  output logic                   frame_clr
);

  logic        rx_act; // frame from server to client port, eof not yet seen
  logic        hdr_ok; // header checks passed, options follow
  logic [15:0] byte_cnt;
  logic [15:0] idx;
  logic        port_ok;
  logic        take;
  logic        hdr_chk;
  logic        hdr_pass;
  logic [31:0] cookie;

  assign port_ok  = (meta.src_port == `DHCP_SRV_PORT) && (meta.dst_port == `DHCP_CLI_PORT);
  assign take     = strm.val && (strm.sof ? port_ok : rx_act);
  assign idx      = strm.sof ? 16'd0 : byte_cnt;
  assign hdr_chk  = take && (idx == `DHCP_HDR_LEN - 1);
  assign hdr_pass = (hdr.op == `DHCP_OP_REPLY) && (hdr.xid == cli_xid) &&
                    ({cookie[23:0], strm.dat} == `DHCP_COOKIE); // last cookie byte is on strm

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx_act    <= 1'b0;
      hdr_ok    <= 1'b0;
      byte_cnt  <= '0;
      opt_en    <= 1'b0;
      hdr_err   <= 1'b0;
      frame_clr <= 1'b0;
      opt_strm  <= '0;
    end
    else begin
      opt_strm  <= strm;
      frame_clr <= strm.val && strm.eof;
      opt_en    <= take && hdr_ok;
      // a header cut short by eof is reported like a failed check
      hdr_err   <= (hdr_chk && !hdr_pass) || (take && strm.eof && idx < `DHCP_HDR_LEN);
      if (hdr_chk && hdr_pass && !strm.eof) hdr_ok <= 1'b1;
      if (strm.val) byte_cnt <= idx + 16'd1;
      if (strm.val && strm.sof) rx_act <= port_ok;
      if (strm.val && strm.eof) begin
        rx_act <= 1'b0;
        hdr_ok <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // fixed field capture
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (frame_clr) cookie <= '0; // stale cookie must not pass a short next frame
    if (take) begin
      if (idx == `DHCP_OFS_OP) hdr.op <= strm.dat;
      if (idx >= `DHCP_OFS_XID && idx < `DHCP_OFS_XID + 4) begin
        hdr.xid <= {hdr.xid[23:0], strm.dat};
      end
      if (idx >= `DHCP_OFS_YIADDR && idx < `DHCP_OFS_YIADDR + 4) begin
        hdr.yiaddr <= {hdr.yiaddr[23:0], strm.dat};
      end
      if (idx >= `DHCP_OFS_SIADDR && idx < `DHCP_OFS_SIADDR + 4) begin
        hdr.siaddr <= {hdr.siaddr[23:0], strm.dat};
      end
      if (idx >= `DHCP_OFS_CHADDR && idx < `DHCP_OFS_CHADDR + 6) begin
        hdr.chaddr <= {hdr.chaddr[39:0], strm.dat};
      end
      if (idx >= `DHCP_OFS_COOKIE && idx < `DHCP_OFS_COOKIE + 4) begin
        cookie <= {cookie[23:0], strm.dat};
      end
    end
  end

  // the source must close every accepted frame before opening another
  a_sof_after_eof : assert property (
    @(posedge clk) disable iff (fsm_rst) (strm.val && strm.sof) |-> !rx_act
  );

endmodule : dhcp_hdr_capture

// ==== hdl/dhcp_opt_parser.sv ====
`timescale 1ns/10ps
`include "dhcp_rx_consts.svh"

module dhcp_opt_parser (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   frame_clr,
  input  dhcp_rx_pkg::udp_strm_t opt_strm,
  input  logic                   opt_en,
  input  dhcp_rx_pkg::dhcp_hdr_t hdr,
  input  logic                   hdr_err,
  output logic                   rsp_push,
  output dhcp_rx_pkg::dhcp_rsp_t rsp,
  output logic                   frame_err
);

  dhcp_rx_pkg::dhcp_opt_field_t  opt_field;
  logic [7:0]                    cur_code;
  logic [7:0]                    opt_left; // payload bytes still to come
  logic [`DHCP_OPT_PLD-1:0][7:0] win;
  dhcp_rx_pkg::dhcp_opt_val_u    opt_val;
  dhcp_rx_pkg::dhcp_opt_hdr_t    opt_hdr;
  dhcp_rx_pkg::dhcp_opt_pres_t   opt_pres;
  logic                          done; // END seen, rest of frame is ignored
  logic                          byte_en;
  logic                          end_now;

  assign byte_en = opt_en && opt_strm.val && !done;
  assign end_now = byte_en && (opt_field == dhcp_rx_pkg::opt_kind) &&
                   (opt_strm.dat == `DHCP_OPT_END);
  assign opt_val = {win[`DHCP_OPT_PLD-2:0], opt_strm.dat}; // window including current byte

  //////////////////////////////////////////////////
  // kind / length / data machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst || frame_clr) begin
      opt_field <= dhcp_rx_pkg::opt_kind;
      cur_code  <= '0;
      opt_left  <= '0;
      win       <= '0;
      opt_hdr   <= '0;
      opt_pres  <= '0;
      done      <= 1'b0;
    end
    else if (byte_en) begin
      case (opt_field)
        dhcp_rx_pkg::opt_kind : begin
          win      <= '0; // short payloads end up right-aligned
          cur_code <= opt_strm.dat;
          case (opt_strm.dat)
            `DHCP_OPT_PAD : ;
            `DHCP_OPT_END : done <= 1'b1;
            default       : opt_field <= dhcp_rx_pkg::opt_len;
          endcase
          case (opt_strm.dat)
            `DHCP_OPT_MSG_TYPE       : opt_pres.msg_type       <= 1'b1;
            `DHCP_OPT_SUBNET_MASK    : opt_pres.subnet_mask    <= 1'b1;
            `DHCP_OPT_ROUTER         : opt_pres.router         <= 1'b1;
            `DHCP_OPT_DNS            : opt_pres.dns            <= 1'b1;
            `DHCP_OPT_SERVER_ID      : opt_pres.server_id      <= 1'b1;
            `DHCP_OPT_REQ_IP         : opt_pres.req_ip         <= 1'b1;
            `DHCP_OPT_LEASE_TIME     : opt_pres.lease_time     <= 1'b1;
            `DHCP_OPT_RENEWAL_TIME   : opt_pres.renewal_time   <= 1'b1;
            `DHCP_OPT_REBINDING_TIME : opt_pres.rebinding_time <= 1'b1;
            `DHCP_OPT_HOSTNAME       : opt_pres.hostname       <= 1'b1;
            `DHCP_OPT_DOMAIN_NAME    : opt_pres.domain_name    <= 1'b1;
            `DHCP_OPT_FQDN           : opt_pres.fqdn           <= 1'b1;
            default                  : ; // unknown codes are skipped by length
          endcase
        end
        dhcp_rx_pkg::opt_len : begin
          opt_left  <= opt_strm.dat;
          opt_field <= (opt_strm.dat == 8'd0) ? dhcp_rx_pkg::opt_kind : dhcp_rx_pkg::opt_data;
          case (cur_code)
            `DHCP_OPT_HOSTNAME    : opt_hdr.hostname_len    <= opt_strm.dat;
            `DHCP_OPT_DOMAIN_NAME : opt_hdr.domain_name_len <= opt_strm.dat;
            `DHCP_OPT_FQDN        : opt_hdr.fqdn_len        <= opt_strm.dat;
            default               : ;
          endcase
        end
        dhcp_rx_pkg::opt_data : begin
          win      <= opt_val.ipv4;
          opt_left <= opt_left - 8'd1;
          if (opt_left == 8'd1) begin
            opt_field <= dhcp_rx_pkg::opt_kind;
            case (cur_code)
              `DHCP_OPT_MSG_TYPE       : opt_hdr.msg_type       <= opt_val.ipv4[0];
              `DHCP_OPT_SUBNET_MASK    : opt_hdr.subnet_mask    <= opt_val.ipv4;
              `DHCP_OPT_ROUTER         : opt_hdr.router         <= opt_val.ipv4;
              `DHCP_OPT_DNS            : opt_hdr.dns            <= opt_val.ipv4;
              `DHCP_OPT_SERVER_ID      : opt_hdr.server_id      <= opt_val.ipv4;
              `DHCP_OPT_REQ_IP         : opt_hdr.req_ip         <= opt_val.ipv4;
              `DHCP_OPT_LEASE_TIME     : opt_hdr.lease_time     <= opt_val.secs;
              `DHCP_OPT_RENEWAL_TIME   : opt_hdr.renewal_time   <= opt_val.secs;
              `DHCP_OPT_REBINDING_TIME : opt_hdr.rebinding_time <= opt_val.secs;
              default                  : ;
            endcase
          end
        end
        default : opt_field <= dhcp_rx_pkg::opt_kind;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // frame result
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rsp_push  <= 1'b0;
      frame_err <= 1'b0;
    end
    else begin
      rsp_push  <= end_now;
      frame_err <= hdr_err || (byte_en && opt_strm.eof && !end_now); // eof before END
    end
  end

  always_ff @(posedge clk) begin
    if (end_now) begin
      rsp.hdr              <= hdr;
      rsp.opt_hdr          <= opt_hdr;
      rsp.opt_pres         <= opt_pres;
      rsp.opt_pres.end_opt <= 1'b1;
    end
  end

  a_push_xor_err : assert property (
    @(posedge clk) disable iff (fsm_rst) !(rsp_push && frame_err)
  );

endmodule : dhcp_opt_parser

// ==== hdl/dhcp_rsp_queue.sv ====
`timescale 1ns/10ps
`include "dhcp_rx_consts.svh"

module dhcp_rsp_queue (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       rsp_push,
  input  dhcp_rx_pkg::dhcp_rsp_t     rsp,
  input  logic                       frame_err,
  input  logic                       rsp_credit,
  output dhcp_rx_pkg::dhcp_rsp_t     rsp_out,
  output logic                       rsp_val,
  output dhcp_rx_pkg::dhcp_rx_stat_t stat
);

  localparam int DEPTH = `DHCP_RSP_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int QW    = $clog2(DEPTH + 1);
  localparam int CW    = $clog2(`DHCP_RSP_CREDITS + 1);

  dhcp_rx_pkg::dhcp_rsp_t mem [DEPTH];
  logic [AW-1:0]          wr_ptr;
  logic [AW-1:0]          rd_ptr;
  logic [QW-1:0]          q_cnt;
  logic [CW-1:0]          credit_cnt;
  logic                   empty;
  logic                   full;
  logic                   pop;
  logic                   bypass;
  logic                   wr_en;
  logic                   rd_en;

  assign empty  = (q_cnt == '0);
  assign full   = (q_cnt == QW'(DEPTH));
  assign pop    = (credit_cnt != '0) && (!empty || rsp_push);
  assign bypass = empty && rsp_push && pop; // straight through, never stored
  assign wr_en  = rsp_push && !full && !bypass;
  assign rd_en  = pop && !empty;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_cnt      <= '0;
      credit_cnt <= CW'(`DHCP_RSP_CREDITS);
      rsp_val    <= 1'b0;
      stat       <= '0;
    end
    else begin
      rsp_val <= pop;
      if (wr_en) wr_ptr <= wr_ptr + AW'(1);
      if (rd_en) rd_ptr <= rd_ptr + AW'(1);
      case ({wr_en, rd_en})
        2'b10   : q_cnt <= q_cnt + QW'(1);
        2'b01   : q_cnt <= q_cnt - QW'(1);
        default : ;
      endcase
      case ({pop, rsp_credit})
        2'b10   : credit_cnt <= credit_cnt - CW'(1);
        2'b01   : credit_cnt <= credit_cnt + CW'(1);
        default : ;
      endcase
      if (rsp_push && !full) stat.frames_ok      <= stat.frames_ok + 16'd1;
      if (rsp_push && full)  stat.frames_dropped <= stat.frames_dropped + 16'd1;
      if (frame_err)         stat.frames_err     <= stat.frames_err + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= rsp;
    if (pop) rsp_out <= empty ? rsp : mem[rd_ptr];
  end

  // the consumer may only return credits it was given
  a_credit_range : assert property (
    @(posedge clk) disable iff (fsm_rst) credit_cnt <= CW'(`DHCP_RSP_CREDITS)
  );

  // equal pointers mean an empty queue unless the count says it is full
  a_no_empty_pop : assert property (
    @(posedge clk) disable iff (fsm_rst) rd_en |-> ((wr_ptr != rd_ptr) || full)
  );

endmodule : dhcp_rsp_queue

// ==== hdl/dhcp_rx_pkg.sv ====
`include "dhcp_rx_consts.svh"

package dhcp_rx_pkg;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } udp_strm_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
  } udp_meta_t;

  //////////////////////////////////////////////////
  // decoded frame
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0]  op;
    logic [31:0] xid;
    logic [31:0] yiaddr;
    logic [31:0] siaddr;
    logic [47:0] chaddr;
  } dhcp_hdr_t;

  typedef enum logic [1:0] {
    opt_kind,
    opt_len,
    opt_data
  } dhcp_opt_field_t;

  typedef struct packed {
    logic msg_type;
    logic subnet_mask;
    logic router;
    logic dns;
    logic server_id;
    logic req_ip;
    logic lease_time;
    logic renewal_time;
    logic rebinding_time;
    logic hostname;
    logic domain_name;
    logic fqdn;
    logic end_opt; // set in every pushed record
  } dhcp_opt_pres_t;

  // the payload window is either an address or a time in seconds
  typedef union packed {
    logic [`DHCP_OPT_PLD-1:0][7:0] ipv4;
    logic [31:0]                   secs;
  } dhcp_opt_val_u;

  typedef struct packed {
    logic [7:0]  msg_type;
    logic [31:0] subnet_mask;
    logic [31:0] router;
    logic [31:0] dns;
    logic [31:0] server_id;
    logic [31:0] req_ip;
    logic [31:0] lease_time;
    logic [31:0] renewal_time;
    logic [31:0] rebinding_time;
    logic [7:0]  hostname_len;
    logic [7:0]  domain_name_len;
    logic [7:0]  fqdn_len;
  } dhcp_opt_hdr_t;

  typedef struct packed {
    dhcp_hdr_t      hdr;
    dhcp_opt_hdr_t  opt_hdr;
    dhcp_opt_pres_t opt_pres;
  } dhcp_rsp_t;

  typedef struct packed {
    logic [15:0] frames_ok;
    logic [15:0] frames_err;
    logic [15:0] frames_dropped;
  } dhcp_rx_stat_t;

endpackage : dhcp_rx_pkg

// ==== hdl/dhcp_rx_top.sv ====
`timescale 1ns/10ps

module dhcp_rx_top (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  dhcp_rx_pkg::udp_strm_t     strm,
  input  dhcp_rx_pkg::udp_meta_t     meta,
  input  logic [31:0]                cli_xid,
  input  logic                       rsp_credit,
  output dhcp_rx_pkg::dhcp_rsp_t     rsp_out,
  output logic                       rsp_val,
  output dhcp_rx_pkg::dhcp_rx_stat_t stat
);

  dhcp_rx_pkg::udp_strm_t opt_strm;
  logic                   opt_en;
  dhcp_rx_pkg::dhcp_hdr_t hdr;
  logic                   hdr_err;
  logic                   frame_clr;
  logic                   rsp_push;
  dhcp_rx_pkg::dhcp_rsp_t rsp;
  logic                   frame_err;

  dhcp_hdr_capture dhcp_hdr_capture_inst (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .strm      (strm),
    .meta      (meta),
    .cli_xid   (cli_xid),
    .opt_strm  (opt_strm),
    .opt_en    (opt_en),
    .hdr       (hdr),
    .hdr_err   (hdr_err),
    .frame_clr (frame_clr)
  );

  dhcp_opt_parser dhcp_opt_parser_inst (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .frame_clr (frame_clr),
    .opt_strm  (opt_strm),
    .opt_en    (opt_en),
    .hdr       (hdr),
    .hdr_err   (hdr_err),
    .rsp_push  (rsp_push),
    .rsp       (rsp),
    .frame_err (frame_err)
  );

  dhcp_rsp_queue dhcp_rsp_queue_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .rsp_push   (rsp_push),
    .rsp        (rsp),
    .frame_err  (frame_err),
    .rsp_credit (rsp_credit),
    .rsp_out    (rsp_out),
    .rsp_val    (rsp_val),
    .stat       (stat)
  );

endmodule : dhcp_rx_top

// ==== include/dhcp_rx_consts.svh ====
`ifndef DHCP_RX_CONSTS_SVH
`define DHCP_RX_CONSTS_SVH

//////////////////////////////////////////////////
// udp ports and fixed header layout
//////////////////////////////////////////////////
`define DHCP_SRV_PORT             16'd67
`define DHCP_CLI_PORT             16'd68
`define DHCP_HDR_LEN              240 // options start at this byte index
`define DHCP_OFS_OP               0
`define DHCP_OFS_XID              4
`define DHCP_OFS_YIADDR           16
`define DHCP_OFS_SIADDR           20
`define DHCP_OFS_CHADDR           28
`define DHCP_OFS_COOKIE           236
`define DHCP_COOKIE               32'h63825363
`define DHCP_OP_REPLY             8'd2

//////////////////////////////////////////////////
// option codes
//////////////////////////////////////////////////
`define DHCP_OPT_PAD              8'd0
`define DHCP_OPT_SUBNET_MASK      8'd1
`define DHCP_OPT_ROUTER           8'd3
`define DHCP_OPT_DNS              8'd6
`define DHCP_OPT_HOSTNAME         8'd12
`define DHCP_OPT_DOMAIN_NAME      8'd15
`define DHCP_OPT_REQ_IP           8'd50
`define DHCP_OPT_LEASE_TIME       8'd51
`define DHCP_OPT_MSG_TYPE         8'd53
`define DHCP_OPT_SERVER_ID        8'd54
`define DHCP_OPT_RENEWAL_TIME     8'd58
`define DHCP_OPT_REBINDING_TIME   8'd59
`define DHCP_OPT_FQDN             8'd81
`define DHCP_OPT_END              8'd255

`define DHCP_OPT_PLD              4 // payload bytes kept per option
`define DHCP_RSP_DEPTH            4
`define DHCP_RSP_CREDITS          2

`endif

// ==== testbench/dhcp_rx_tb.sv ====
`timescale 1ns/10ps
`include "dhcp_rx_consts.svh"

module dhcp_rx_tb;

  localparam int          num_rows   = 15;
  localparam logic [31:0] client_xid = 32'h3903f326;

  typedef struct packed {
    logic [15:0]                src_port;
    logic [15:0]                dst_port;
    logic [31:0]                xid;
    logic [7:0]                 op;
    logic [31:0]                cookie;
    logic [31:0]                yiaddr;
    logic [31:0]                siaddr;
    logic [47:0]                chaddr;
    logic [8*48-1:0]            opts; // option bytes, the latest one in the low byte
    logic [7:0]                 opt_n;
    logic                       trunc; // eof on the last option byte, no END
    logic                       hold;  // consumer keeps its credits
    logic                       rec;   // a record is expected on rsp_out
    dhcp_rx_pkg::dhcp_rx_stat_t delta;
    dhcp_rx_pkg::dhcp_rsp_t     exp;
  } frame_row_t;

  logic                       clk = 1'b0;
  logic                       fsm_rst;
  dhcp_rx_pkg::udp_strm_t     strm;
  dhcp_rx_pkg::udp_meta_t     meta;
  logic [31:0]                cli_xid;
  logic                       rsp_credit;
  dhcp_rx_pkg::dhcp_rsp_t     rsp_out;
  logic                       rsp_val;
  dhcp_rx_pkg::dhcp_rx_stat_t stat;

  frame_row_t                 tbl [num_rows];
  string                      names [num_rows];
  dhcp_rx_pkg::dhcp_rsp_t     got [$];
  int                         exp_q [$];
  dhcp_rx_pkg::dhcp_rx_stat_t exp_stat;
  logic [31:0]                lcg_state = 32'h8a17;
  logic                       hold_credits = 1'b0;
  int                         credits = `DHCP_RSP_CREDITS;
  int                         owed = 0;
  logic [1:0]                 ret_pipe = 2'b00;
  int                         err_cnt = 0;
  int                         n_fail = 0;
  int                         cycle_cnt = 0;
  int                         cycle_limit = 1000000;
  int                         total;
  int                         waited;
  int                         errs_before;
  int                         r;

  dhcp_rx_top dhcp_rx_top_inst (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .strm       (strm),
    .meta       (meta),
    .cli_xid    (cli_xid),
    .rsp_credit (rsp_credit),
    .rsp_out    (rsp_out),
    .rsp_val    (rsp_val),
    .stat       (stat)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int frame_len(input int row);
    return `DHCP_HDR_LEN + tbl[row].opt_n + (tbl[row].trunc ? 0 : 2);
  endfunction

  task automatic put_byte(input int row, input logic [7:0] b);
    tbl[row].opts  = {tbl[row].opts[8*47-1:0], b};
    tbl[row].opt_n = tbl[row].opt_n + 8'd1;
  endtask

  task automatic put_opt(input int row, input logic [7:0] code, input logic [7:0] len,
                         input logic [127:0] val);
    int j;
    put_byte(row, code);
    put_byte(row, len);
    for (j = len - 1; j >= 0; j--) put_byte(row, val[8*j +: 8]); // value goes out msb first
  endtask

  task automatic new_row(input int row, input string name, input logic [31:0] yi);
    names[row]                   = name;
    tbl[row]                     = '0;
    tbl[row].src_port            = `DHCP_SRV_PORT;
    tbl[row].dst_port            = `DHCP_CLI_PORT;
    tbl[row].xid                 = client_xid;
    tbl[row].op                  = `DHCP_OP_REPLY;
    tbl[row].cookie              = `DHCP_COOKIE;
    tbl[row].yiaddr              = yi;
    tbl[row].siaddr              = 32'hc0a80001;
    tbl[row].chaddr              = 48'h02005e10a3c7;
    tbl[row].rec                 = 1'b1;
    tbl[row].delta.frames_ok     = 16'd1;
    tbl[row].exp.hdr             = {`DHCP_OP_REPLY, client_xid, yi, 32'hc0a80001, 48'h02005e10a3c7};
    tbl[row].exp.opt_pres.end_opt = 1'b1;
  endtask

  task automatic no_record(input int row, input logic err);
    tbl[row].rec              = 1'b0;
    tbl[row].delta.frames_ok  = 16'd0;
    tbl[row].delta.frames_err = {15'd0, err};
  endtask

  //////////////////////////////////////////////////
  // frame table
  //////////////////////////////////////////////////
  task automatic load_table();
    int k;
    new_row(0, "offer", 32'hc0a8000a);
    put_opt(0, `DHCP_OPT_MSG_TYPE, 8'd1, 8'd2);
    put_opt(0, `DHCP_OPT_SUBNET_MASK, 8'd4, 32'hffffff00);
    put_opt(0, `DHCP_OPT_ROUTER, 8'd4, 32'hc0a800fe);
    put_opt(0, `DHCP_OPT_SERVER_ID, 8'd4, 32'hc0a80001);
    put_opt(0, `DHCP_OPT_LEASE_TIME, 8'd4, 32'd86400);
    tbl[0].exp.opt_hdr.msg_type    = 8'd2;
    tbl[0].exp.opt_hdr.subnet_mask = 32'hffffff00;
    tbl[0].exp.opt_hdr.router      = 32'hc0a800fe;
    tbl[0].exp.opt_hdr.server_id   = 32'hc0a80001;
    tbl[0].exp.opt_hdr.lease_time  = 32'd86400;
    tbl[0].exp.opt_pres            = 13'b1110101000001;
    new_row(1, "opt_mix", 32'hc0a8000b);
    put_byte(1, `DHCP_OPT_PAD);
    put_byte(1, `DHCP_OPT_PAD);
    put_opt(1, 8'd200, 8'd3, 24'h010203); // unknown code
    put_opt(1, `DHCP_OPT_HOSTNAME, 8'd9, "dhcp-host");
    put_opt(1, `DHCP_OPT_ROUTER, 8'd8, 64'h0a000001_0a000002);
    put_byte(1, `DHCP_OPT_PAD);
    put_opt(1, `DHCP_OPT_MSG_TYPE, 8'd1, 8'd5);
    tbl[1].exp.opt_hdr.msg_type     = 8'd5;
    tbl[1].exp.opt_hdr.router       = 32'h0a000002;
    tbl[1].exp.opt_hdr.hostname_len = 8'd9;
    tbl[1].exp.opt_pres             = 13'b1010000001001;
    for (k = 2; k < 6; k++) begin
      new_row(k, "", 32'hc0a8000a);
      put_opt(k, `DHCP_OPT_MSG_TYPE, 8'd1, 8'd2);
      no_record(k, k != 2);
    end
    names[2] = "wrong_port";
    tbl[2].src_port = 16'd5353;
    names[3] = "bad_xid";
    tbl[3].xid = client_xid ^ 32'h1;
    names[4] = "bad_cookie";
    tbl[4].cookie = 32'h63825364;
    names[5] = "op_request";
    tbl[5].op = 8'd1;
    new_row(6, "truncated", 32'hc0a8000a);
    put_opt(6, `DHCP_OPT_MSG_TYPE, 8'd1, 8'd2);
    put_byte(6, `DHCP_OPT_SUBNET_MASK);
    put_byte(6, 8'd4);
    put_byte(6, 8'hff);
    tbl[6].trunc = 1'b1;
    no_record(6, 1'b1);
    new_row(7, "after_trunc", 32'hc0a8000c);
    put_opt(7, `DHCP_OPT_MSG_TYPE, 8'd1, 8'd5);
    put_opt(7, `DHCP_OPT_DNS, 8'd4, 32'h08080808);
    put_opt(7, `DHCP_OPT_REQ_IP, 8'd4, 32'hc0a8000c);
    put_opt(7, `DHCP_OPT_RENEWAL_TIME, 8'd4, 32'd43200);
    put_opt(7, `DHCP_OPT_REBINDING_TIME, 8'd4, 32'd75600);
    put_opt(7, `DHCP_OPT_DOMAIN_NAME, 8'd7, "example");
    put_opt(7, `DHCP_OPT_FQDN, 8'd3, "abc");
    tbl[7].exp.opt_hdr.msg_type        = 8'd5;
    tbl[7].exp.opt_hdr.dns             = 32'h08080808;
    tbl[7].exp.opt_hdr.req_ip          = 32'hc0a8000c;
    tbl[7].exp.opt_hdr.renewal_time    = 32'd43200;
    tbl[7].exp.opt_hdr.rebinding_time  = 32'd75600;
    tbl[7].exp.opt_hdr.domain_name_len = 8'd7;
    tbl[7].exp.opt_hdr.fqdn_len        = 8'd3;
    tbl[7].exp.opt_pres                = 13'b1001010110111; // mask bit of the cut frame is gone
    for (k = 0; k < 7; k++) begin
      new_row(8 + k, $sformatf("backpress_%0d", k), 32'hc0a80010 + k);
      put_opt(8 + k, `DHCP_OPT_MSG_TYPE, 8'd1, 8'd2);
      put_opt(8 + k, `DHCP_OPT_LEASE_TIME, 8'd4, 32'd3600);
      tbl[8 + k].hold                   = 1'b1;
      tbl[8 + k].exp.opt_hdr.msg_type   = 8'd2;
      tbl[8 + k].exp.opt_hdr.lease_time = 32'd3600;
      tbl[8 + k].exp.opt_pres           = 13'b1000001000001;
    end
    no_record(14, 1'b0); // 2 sent and 4 queued, so this one finds the queue full
    tbl[14].delta.frames_dropped = 16'd1;
  endtask

  task automatic send_frame(input int row);
    logic [7:0] fb [0:299];
    int         n;
    int         k;
    n = frame_len(row);
    for (k = 0; k < `DHCP_HDR_LEN; k++) begin
      lcg_state = lcg_next(lcg_state);
      fb[k]     = lcg_state[23:16];
    end
    fb[`DHCP_OFS_OP] = tbl[row].op;
    for (k = 0; k < 4; k++) begin
      fb[`DHCP_OFS_XID + k]    = tbl[row].xid[8*(3-k) +: 8];
      fb[`DHCP_OFS_YIADDR + k] = tbl[row].yiaddr[8*(3-k) +: 8];
      fb[`DHCP_OFS_SIADDR + k] = tbl[row].siaddr[8*(3-k) +: 8];
      fb[`DHCP_OFS_COOKIE + k] = tbl[row].cookie[8*(3-k) +: 8];
    end
    for (k = 0; k < 6; k++) fb[`DHCP_OFS_CHADDR + k] = tbl[row].chaddr[8*(5-k) +: 8];
    for (k = 0; k < tbl[row].opt_n; k++) begin
      fb[`DHCP_HDR_LEN + k] = tbl[row].opts[8*(tbl[row].opt_n-1-k) +: 8];
    end
    if (!tbl[row].trunc) begin
      fb[n-2] = `DHCP_OPT_END;
      fb[n-1] = 8'h5a; // trailing byte after END is ignored
    end
    for (k = 0; k < n; k++) begin
      @(negedge clk);
      strm = '{dat: fb[k], val: 1'b1, sof: (k == 0), eof: (k == n - 1)};
      meta = '{src_port: tbl[row].src_port, dst_port: tbl[row].dst_port, length: 16'(n + 8)};
    end
    @(negedge clk);
    strm = '0;
    meta = '0;
  endtask

  task automatic check_field(input string name, input string what,
                             input logic [287:0] exp_v, input logic [287:0] act_v);
    assert (act_v === exp_v) else begin
      $display("MISMATCH %s %s expected %0h actual %0h", name, what, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic check_records();
    dhcp_rx_pkg::dhcp_rsp_t act;
    int                     idx;
    while (got.size() > 0) begin
      act = got.pop_front();
      assert (exp_q.size() > 0) else begin
        $display("a record for yiaddr %0h arrived that no frame should give", act.hdr.yiaddr);
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        idx = exp_q.pop_front();
        check_field(names[idx], "hdr", tbl[idx].exp.hdr, act.hdr);
        check_field(names[idx], "opt_hdr", tbl[idx].exp.opt_hdr, act.opt_hdr);
        check_field(names[idx], "opt_pres", tbl[idx].exp.opt_pres, act.opt_pres);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // consumer with credit return and record capture
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (fsm_rst) begin
      credits    = `DHCP_RSP_CREDITS;
      owed       = 0;
      ret_pipe   = 2'b00;
      rsp_credit = 1'b0;
    end
    else begin
      rsp_credit = ret_pipe[1];
      if (ret_pipe[1]) credits++;
      ret_pipe = {ret_pipe[0], 1'b0};
      if (rsp_val) begin
        assert (credits > 0) else begin
          $display("rsp_val fired while the consumer had no credit left");
          err_cnt++;
        end
        credits--;
        owed++;
        got.push_back(rsp_out);
      end
      if (!hold_credits && owed > 0) begin // one credit back per cycle
        ret_pipe[0] = 1'b1;
        owed--;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the run did not complete", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    fsm_rst    = 1'b1;
    strm       = '0;
    meta       = '0;
    cli_xid    = client_xid;
    rsp_credit = 1'b0;
    exp_stat   = '0;
    load_table();
    total = 0;
    for (r = 0; r < num_rows; r++) total += frame_len(r);
    cycle_limit = 4 * total + 200;
    repeat (16) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    for (r = 0; r < num_rows; r++) begin
      errs_before = err_cnt;
      @(posedge clk);
      hold_credits = tbl[r].hold;
      send_frame(r);
      repeat (3) @(negedge clk); // push or frame_err lands within 2 cycles of the last byte
      exp_stat.frames_ok      = exp_stat.frames_ok + tbl[r].delta.frames_ok;
      exp_stat.frames_err     = exp_stat.frames_err + tbl[r].delta.frames_err;
      exp_stat.frames_dropped = exp_stat.frames_dropped + tbl[r].delta.frames_dropped;
      if (tbl[r].rec) exp_q.push_back(r);
      waited = 0;
      while (stat !== exp_stat && waited < 20) begin
        @(negedge clk);
        waited++;
      end
      check_field(names[r], "stat", exp_stat, stat);
      repeat (2) @(posedge clk);
      check_records();
      if (err_cnt != errs_before) n_fail++;
      $display("%s: %s", names[r], (err_cnt == errs_before) ? "ok" : "FAILED");
    end

    // release the held credits, the queued records drain in order
    errs_before = err_cnt;
    @(posedge clk);
    hold_credits = 1'b0;
    waited = 0;
    while (got.size() < exp_q.size() && waited < 40) begin
      @(posedge clk);
      waited++;
    end
    check_records();
    assert (exp_q.size() == 0) else begin
      $display("%0d queued records never came out after credits were released", exp_q.size());
      err_cnt++;
    end
    @(negedge clk);
    check_field("credit_release", "stat", exp_stat, stat);
    if (err_cnt != errs_before) n_fail++;
    $display("credit_release: %s", (err_cnt == errs_before) ? "ok" : "FAILED");
    $display("%0d tests, %0d failed, %0d errors", num_rows + 1, n_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end
    else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : dhcp_rx_tb
